// ==== src/pcie_bridge_macros.svh ====
// Width and LED constants shared by the TLP width bridge
// Core side is fixed at 64 bits, user side at 128 bits
// Keep widths must stay consistent with the data widths below

`ifndef PCIE_BRIDGE_MACROS_SVH
`define PCIE_BRIDGE_MACROS_SVH

// ----------------------------------------
// TLP stream widths
// ----------------------------------------
`define TLP_CORE_W          64
`define TLP_USER_W          128
`define TLP_DW_W            32
`define TLP_CORE_KEEP_W     8
`define TLP_USER_KEEPDW_W   4

// Core receive user bits carry the BAR hit at bits 8:2
`define TLP_BAR_HIT_W       7
`define TLP_RX_USER_W       22
`define TLP_BAR_HIT_LSB     2

// Packer holds at most four dwords
`define TLP_FILL_W          4

// ----------------------------------------
// Link LED
// ----------------------------------------
`define LED_TICK_W              32
`define LED_BLINK_BIT_DEFAULT   25

`endif

// ==== src/tlp_stream_pkg.sv ====
// Vector types for the 64-bit core and 128-bit user TLP streams
// Widths come from the bridge macro header

`include "pcie_bridge_macros.svh"

package tlp_stream_pkg;

    // ----------------------------------------
    // Core side (64-bit)
    // ----------------------------------------
    typedef logic [`TLP_CORE_W-1:0]       core_data_t;
    typedef logic [`TLP_CORE_KEEP_W-1:0]  core_keep_t;

    // Receive user bits straight from the core
    typedef logic [`TLP_RX_USER_W-1:0]    core_rx_user_t;

    // ----------------------------------------
    // User side (128-bit)
    // ----------------------------------------
    typedef logic [`TLP_USER_W-1:0]        user_data_t;

    // One bit per dword, contiguous from dword 0
    typedef logic [`TLP_USER_KEEPDW_W-1:0] keepdw_t;

    typedef logic [`TLP_BAR_HIT_W-1:0]     bar_hit_t;

    // Dwords currently collected by the receive packer
    typedef logic [`TLP_FILL_W-1:0]        fill_t;

endpackage

// ==== src/link_status_pkg.sv ====
// Vector types for the link status LED
// The blink select is wide enough to index any counter bit

`include "pcie_bridge_macros.svh"

package link_status_pkg;

    // Free-running tick counter
    typedef logic [`LED_TICK_W-1:0] led_tick_t;

    // Bit index into led_tick_t
    typedef logic [$clog2(`LED_TICK_W)-1:0] blink_sel_t;

endpackage

// ==== src/tlp_rx_packer.sv ====
// Packs 64-bit core receive beats into 128-bit user beats
// rx_ready is tied high; the user side has no ready and must take every beat
// Only the last core beat of a TLP may carry a half keep (8'h0f)
// Output beats appear one clock after the completing core beat

`timescale 1ns/1ps
`include "pcie_bridge_macros.svh"

module tlp_rx_packer (
    input  logic                          clk_pcie,
    input  logic                          rst,

    // Core receive stream
    input  tlp_stream_pkg::core_data_t    rx_data,
    input  tlp_stream_pkg::core_keep_t    rx_keep,
    input  logic                          rx_last,
    input  tlp_stream_pkg::core_rx_user_t rx_user,
    input  logic                          rx_valid,
    output logic                          rx_ready,

    // User receive stream
    output tlp_stream_pkg::user_data_t    rx128_data,
    output tlp_stream_pkg::keepdw_t       rx128_keepdw,
    output logic                          rx128_first,
    output logic                          rx128_last,
    output tlp_stream_pkg::bar_hit_t      rx128_bar_hit,
    output logic                          rx128_valid
);

    tlp_stream_pkg::user_data_t data_q;
    tlp_stream_pkg::bar_hit_t   bar_hit_q;
    tlp_stream_pkg::fill_t      fill_q;
    tlp_stream_pkg::fill_t      base;
    tlp_stream_pkg::fill_t      fill_next;
    logic                       last_q;
    logic                       first_q;
    logic                       beat_out;

    assign rx_ready = 1'b1;

    // A beat is complete with three or four dwords, or at end of TLP
    assign beat_out = last_q || (fill_q > tlp_stream_pkg::fill_t'(2));

    // Restart at dword 0 once the held beat is issued
    assign base      = beat_out ? '0 : fill_q;
    assign fill_next = base + tlp_stream_pkg::fill_t'(1)
                     + tlp_stream_pkg::fill_t'(rx_keep[4]);

    // ----------------------------------------
    // Fill count and framing
    // ----------------------------------------
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            fill_q  <= '0;
            last_q  <= 1'b0;
            first_q <= 1'b1;
        end else if (rx_valid) begin
            fill_q <= fill_next;
            last_q <= rx_last;
            if (beat_out) begin
                first_q <= last_q;
            end
        end else if (beat_out) begin
            fill_q  <= '0;
            last_q  <= 1'b0;
            first_q <= last_q;
        end
    end

    // ----------------------------------------
    // Payload placement
    // ----------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            for (int i = 0; i < `TLP_USER_KEEPDW_W; i++) begin
                if (i == base) begin
                    data_q[`TLP_DW_W*i +: `TLP_DW_W] <= rx_data[`TLP_DW_W-1:0];
                end
                // Upper dword lands next; harmless when its keep is clear
                if (i == base + tlp_stream_pkg::fill_t'(1)) begin
                    data_q[`TLP_DW_W*i +: `TLP_DW_W] <= rx_data[2*`TLP_DW_W-1:`TLP_DW_W];
                end
            end
            bar_hit_q <= rx_user[`TLP_BAR_HIT_LSB +: `TLP_BAR_HIT_W];
        end
    end

    assign rx128_data    = data_q;
    assign rx128_keepdw  = {fill_q > tlp_stream_pkg::fill_t'(3),
                            fill_q > tlp_stream_pkg::fill_t'(2),
                            fill_q > tlp_stream_pkg::fill_t'(1),
                            1'b1};
    assign rx128_first   = first_q;
    assign rx128_last    = last_q;
    assign rx128_bar_hit = bar_hit_q;
    assign rx128_valid   = beat_out;

    // Core only ever sends whole or half qwords
    a_rx_keep_shape: assert property (
        @(posedge clk_pcie) disable iff (rst)
        rx_valid |-> (rx_keep == 8'h0f || rx_keep == 8'hff)
    );

endmodule

// ==== src/tlp_tx_splitter.sv ====
// Splits 128-bit user transmit beats into one or two 64-bit core beats
// tx128_keepdw must be contiguous from dword 0
// The source must hold a beat until tx128_ready accepts it

`timescale 1ns/1ps
`include "pcie_bridge_macros.svh"

module tlp_tx_splitter (
    input  logic                       clk_pcie,
    input  logic                       rst,

    // User transmit stream
    input  tlp_stream_pkg::user_data_t tx128_data,
    input  tlp_stream_pkg::keepdw_t    tx128_keepdw,
    input  logic                       tx128_last,
    input  logic                       tx128_valid,
    output logic                       tx128_ready,

    // Core transmit stream
    output tlp_stream_pkg::core_data_t tx_data,
    output tlp_stream_pkg::core_keep_t tx_keep,
    output logic                       tx_last,
    output logic                       tx_valid,
    input  logic                       tx_ready
);

    tlp_stream_pkg::core_data_t hold_data;
    logic                       hold_last;
    logic                       hold_keep_hi;
    logic                       hold_valid;
    logic                       split_beat;
    logic                       upper_kept;

    // Beat needs a second core beat for its high qword
    assign split_beat = tx128_valid && tx128_keepdw[2];

    // Two-half beat is only taken together with its held half
    assign tx128_ready = tx_ready && (hold_valid || !split_beat);

    // ----------------------------------------
    // Core side mux
    // ----------------------------------------
    assign tx_valid   = hold_valid || tx128_valid;
    assign tx_data    = hold_valid ? hold_data : tx128_data[`TLP_CORE_W-1:0];
    assign tx_last    = hold_valid ? hold_last : (tx128_last && !tx128_keepdw[2]);
    assign upper_kept = hold_valid ? hold_keep_hi : tx128_keepdw[1];
    assign tx_keep    = upper_kept ? {`TLP_CORE_KEEP_W{1'b1}}
                                   : {{(`TLP_CORE_KEEP_W/2){1'b0}},
                                      {(`TLP_CORE_KEEP_W/2){1'b1}}};

    // Pending flag for the high qword
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (hold_valid) begin
            if (tx_ready) begin
                hold_valid <= 1'b0;
            end
        end else if (split_beat && tx_ready) begin
            hold_valid <= 1'b1;
        end
    end

    // Capture the high half when the low half is accepted
    always_ff @(posedge clk_pcie) begin
        if (!hold_valid && split_beat && tx_ready) begin
            hold_data    <= tx128_data[`TLP_USER_W-1:`TLP_CORE_W];
            hold_last    <= tx128_last;
            hold_keep_hi <= tx128_keepdw[3];
        end
    end

    // Core sees a stable qword until it takes it
    a_tx_data_stable: assert property (
        @(posedge clk_pcie) disable iff (rst)
        (tx_valid && !tx_ready) |=> $stable(tx_data)
    );

endmodule

// ==== src/link_led.sv ====
// Link-state LED driver
// Solid on while the link is up, otherwise blinks from a counter bit
// Blink rate is clk_pcie / 2^(BLINK_BIT+1)

`timescale 1ns/1ps
`include "pcie_bridge_macros.svh"

module link_led #(
    parameter link_status_pkg::blink_sel_t BLINK_BIT = `LED_BLINK_BIT_DEFAULT
) (
    input  logic clk_pcie,
    input  logic rst,
    input  logic link_up,
    output logic led_state
);

    link_status_pkg::led_tick_t tick_q;

    // Free-running tick counter
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            tick_q <= '0;
        end else begin
            tick_q <= tick_q + 1'b1;
        end
    end

    assign led_state = link_up || tick_q[BLINK_BIT];

endmodule

// ==== src/tlp_width_bridge.sv ====
// TLP width bridge between a 64-bit PCIe core stream and a 128-bit user stream
// All logic runs on the core user clock clk_pcie
// Receive packer and LED use the combined subsystem reset
// Transmit splitter is reset by rst alone

`timescale 1ns/1ps
`include "pcie_bridge_macros.svh"

module tlp_width_bridge #(
    parameter link_status_pkg::blink_sel_t BLINK_BIT = `LED_BLINK_BIT_DEFAULT
) (
    input  logic                          clk_pcie,
    input  logic                          rst,
    input  logic                          core_user_rst,
    input  logic                          host_rst_subsys,
    input  logic                          link_up,
    output logic                          led_state,

    // Core receive stream
    input  tlp_stream_pkg::core_data_t    rx_data,
    input  tlp_stream_pkg::core_keep_t    rx_keep,
    input  logic                          rx_last,
    input  tlp_stream_pkg::core_rx_user_t rx_user,
    input  logic                          rx_valid,
    output logic                          rx_ready,

    // User receive stream
    output tlp_stream_pkg::user_data_t    rx128_data,
    output tlp_stream_pkg::keepdw_t       rx128_keepdw,
    output logic                          rx128_first,
    output logic                          rx128_last,
    output tlp_stream_pkg::bar_hit_t      rx128_bar_hit,
    output logic                          rx128_valid,

    // User transmit stream
    input  tlp_stream_pkg::user_data_t    tx128_data,
    input  tlp_stream_pkg::keepdw_t       tx128_keepdw,
    input  logic                          tx128_last,
    input  logic                          tx128_valid,
    output logic                          tx128_ready,

    // Core transmit stream
    output tlp_stream_pkg::core_data_t    tx_data,
    output tlp_stream_pkg::core_keep_t    tx_keep,
    output logic                          tx_last,
    output logic                          tx_valid,
    input  logic                          tx_ready
);

    logic rst_subsys;

    // Any of system, core or host reset clears the subsystem
    assign rst_subsys = rst || core_user_rst || host_rst_subsys;

    // ----------------------------------------
    // Receive path
    // ----------------------------------------
    tlp_rx_packer tlp_rx_packer_inst (
        .clk_pcie      ( clk_pcie      ),
        .rst           ( rst_subsys    ),
        .rx_data       ( rx_data       ),
        .rx_keep       ( rx_keep       ),
        .rx_last       ( rx_last       ),
        .rx_user       ( rx_user       ),
        .rx_valid      ( rx_valid      ),
        .rx_ready      ( rx_ready      ),
        .rx128_data    ( rx128_data    ),
        .rx128_keepdw  ( rx128_keepdw  ),
        .rx128_first   ( rx128_first   ),
        .rx128_last    ( rx128_last    ),
        .rx128_bar_hit ( rx128_bar_hit ),
        .rx128_valid   ( rx128_valid   )
    );

    // ----------------------------------------
    // Transmit path
    // ----------------------------------------
    tlp_tx_splitter tlp_tx_splitter_inst (
        .clk_pcie     ( clk_pcie     ),
        .rst          ( rst          ),
        .tx128_data   ( tx128_data   ),
        .tx128_keepdw ( tx128_keepdw ),
        .tx128_last   ( tx128_last   ),
        .tx128_valid  ( tx128_valid  ),
        .tx128_ready  ( tx128_ready  ),
        .tx_data      ( tx_data      ),
        .tx_keep      ( tx_keep      ),
        .tx_last      ( tx_last      ),
        .tx_valid     ( tx_valid     ),
        .tx_ready     ( tx_ready     )
    );

    // Status LED
    link_led #(
        .BLINK_BIT ( BLINK_BIT )
    ) link_led_inst (
        .clk_pcie  ( clk_pcie   ),
        .rst       ( rst_subsys ),
        .link_up   ( link_up    ),
        .led_state ( led_state  )
    );

endmodule

// ==== test/tlp_bridge_cases.svh ====
// Case table for the TLP width bridge testbench
// Included inside the testbench module, so it may use package types directly
// Host reset rows need at least three dwords so no beat leaves before the reset

`ifndef TLP_BRIDGE_CASES_SVH
`define TLP_BRIDGE_CASES_SVH

typedef struct packed {
    logic [3:0]               len;
    tlp_stream_pkg::bar_hit_t bar;
    logic [31:0]              seed;
    logic                     is_rx;
    logic                     rand_mode;
    logic                     host_rst;
} tlp_case_t;

localparam int NUM_CASES = 18;

// Each row holds length in dwords, BAR hit, data seed, receive, gaps or back-pressure, host reset
localparam tlp_case_t CASES [NUM_CASES] = '{
    '{4'd4,  7'h01, 32'h0000_1000, 1'b1, 1'b0, 1'b0},
    '{4'd8,  7'h02, 32'h0000_2000, 1'b1, 1'b0, 1'b0},
    '{4'd1,  7'h04, 32'h0000_3000, 1'b1, 1'b0, 1'b0},
    '{4'd3,  7'h08, 32'h0000_4000, 1'b1, 1'b0, 1'b0},
    '{4'd12, 7'h10, 32'h1234_0000, 1'b1, 1'b1, 1'b0},
    '{4'd5,  7'h20, 32'h00ab_cd00, 1'b1, 1'b1, 1'b0},
    // Partial TLP dropped by the host reset
    '{4'd7,  7'h40, 32'h0bad_0000, 1'b1, 1'b0, 1'b1},
    '{4'd6,  7'h03, 32'h0000_5000, 1'b1, 1'b0, 1'b0},
    '{4'd2,  7'h05, 32'h0000_6000, 1'b1, 1'b1, 1'b0},
    // BAR hit is unused in transmit rows
    '{4'd4,  7'h00, 32'h7700_0000, 1'b0, 1'b0, 1'b0},
    '{4'd3,  7'h00, 32'h7800_0000, 1'b0, 1'b0, 1'b0},
    '{4'd12, 7'h00, 32'h7900_0000, 1'b0, 1'b1, 1'b0},
    '{4'd1,  7'h00, 32'h7a00_0000, 1'b0, 1'b1, 1'b0},
    '{4'd9,  7'h00, 32'h7b00_0000, 1'b0, 1'b1, 1'b0},
    '{4'd6,  7'h00, 32'h7c00_0000, 1'b0, 1'b0, 1'b0},
    '{4'd9,  7'h7f, 32'h0dea_d000, 1'b1, 1'b0, 1'b1},
    '{4'd10, 7'h11, 32'h0000_8000, 1'b1, 1'b1, 1'b0},
    '{4'd2,  7'h00, 32'h7d00_0000, 1'b0, 1'b1, 1'b0}
};

`endif

// ==== test/tlp_bridge_tb.sv ====
// Self-checking testbench for the TLP width bridge
// Cases from the case table run one at a time, receive rows back to back
// Payload, receive gaps and core back-pressure come from a 32-bit LFSR
// Outputs are sampled on the falling edge, inputs driven 2 ns after the rising edge

`timescale 1ns/1ps

module tlp_bridge_tb;

    `include "tlp_bridge_cases.svh"

    // Expected user receive beat with the cycle it must show up in
    typedef struct packed {
        tlp_stream_pkg::user_data_t data;
        tlp_stream_pkg::keepdw_t    keepdw;
        logic                       first;
        logic                       last;
        tlp_stream_pkg::bar_hit_t   bar;
        int                         cyc;
    } rx_beat_t;

    typedef struct packed {
        tlp_stream_pkg::core_data_t data;
        tlp_stream_pkg::core_keep_t keep;
        logic                       last;
    } tx_beat_t;

    logic                          clk_pcie;
    logic                          rst;
    logic                          core_user_rst;
    logic                          host_rst_subsys;
    logic                          link_up;
    logic                          led_state;
    tlp_stream_pkg::core_data_t    rx_data;
    tlp_stream_pkg::core_keep_t    rx_keep;
    logic                          rx_last;
    tlp_stream_pkg::core_rx_user_t rx_user;
    logic                          rx_valid;
    logic                          rx_ready;
    tlp_stream_pkg::user_data_t    rx128_data;
    tlp_stream_pkg::keepdw_t       rx128_keepdw;
    logic                          rx128_first;
    logic                          rx128_last;
    tlp_stream_pkg::bar_hit_t      rx128_bar_hit;
    logic                          rx128_valid;
    tlp_stream_pkg::user_data_t    tx128_data;
    tlp_stream_pkg::keepdw_t       tx128_keepdw;
    logic                          tx128_last;
    logic                          tx128_valid;
    logic                          tx128_ready;
    tlp_stream_pkg::core_data_t    tx_data;
    tlp_stream_pkg::core_keep_t    tx_keep;
    logic                          tx_last;
    logic                          tx_valid;
    logic                          tx_ready;

    logic [31:0]                   lfsr_state = 32'h5e34;
    logic [31:0]                   payload [12];
    rx_beat_t                      rx_exp [$];
    tx_beat_t                      tx_exp [$];
    link_status_pkg::led_tick_t    led_model;
    logic                          model_rst;
    logic                          checks_on;
    int                            cyc;

    tlp_width_bridge #(
        .BLINK_BIT ( 5'd3 )
    ) tlp_width_bridge_inst (.*);

    initial begin
        clk_pcie = 1'b0;
        forever #20 clk_pcie = ~clk_pcie;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_rand_bit()};
        end
        return r;
    endfunction

    function automatic int total_dwords();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            sum = sum + int'(CASES[i].len);
        end
        return sum;
    endfunction

    task automatic fill_payload(input logic [31:0] seed, input int len);
        for (int k = 0; k < 12; k++) begin
            payload[k] = 32'h0;
            if (k < len) begin
                payload[k] = rand_bits(32) ^ (seed + k);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_pcie);
        #2;
    endtask

    task automatic report_fail(input string what);
        $display("Fail at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    // ----------------------------------------
    // Receive drivers
    // ----------------------------------------
    task automatic push_rx_beat(input int g, input int len,
                                input tlp_stream_pkg::bar_hit_t bar);
        rx_beat_t e;
        int       cnt;
        cnt = len - 4 * g;
        if (cnt > 4) begin
            cnt = 4;
        end
        e = '0;
        for (int k = 0; k < cnt; k++) begin
            e.data[32*k +: 32] = payload[4*g+k];
            e.keepdw[k] = 1'b1;
        end
        e.first = (g == 0);
        e.last  = (4 * g + cnt == len);
        e.bar   = bar;
        // Due one clock after the completing core beat
        e.cyc   = cyc + 1;
        rx_exp.push_back(e);
    endtask

    task automatic drive_core_beat(input int j, input int len,
                                   input tlp_stream_pkg::bar_hit_t bar);
        logic [31:0] upper;
        logic [31:0] noise;
        if (2 * j + 1 < len) begin
            upper   = payload[2*j+1];
            rx_keep = 8'hff;
        end else begin
            upper   = rand_bits(32);
            rx_keep = 8'h0f;
        end
        noise    = rand_bits(15);
        rx_data  = {upper, payload[2*j]};
        rx_last  = (2 * j + 2 >= len);
        rx_user  = {noise[14:2], bar, noise[1:0]};
        rx_valid = 1'b1;
    endtask

    task automatic run_rx_case(input tlp_case_t tc, input logic keep_valid);
        int nbeats;
        int gap;
        fill_payload(tc.seed, tc.len);
        nbeats = (int'(tc.len) + 1) / 2;
        for (int j = 0; j < nbeats; j++) begin
            if (tc.rand_mode) begin
                gap = rand_bits(2);
                repeat (gap) begin
                    next_cycle();
                    rx_valid = 1'b0;
                end
            end
            next_cycle();
            drive_core_beat(j, tc.len, tc.bar);
            if (j % 2 == 1 || j == nbeats - 1) begin
                push_rx_beat(j / 2, tc.len, tc.bar);
            end
        end
        // Next receive row follows with no idle cycle
        if (!keep_valid) begin
            next_cycle();
            rx_valid = 1'b0;
        end
    endtask

    // First qword only, then a host reset drops the partial TLP
    task automatic run_rx_reset_case(input tlp_case_t tc);
        fill_payload(tc.seed, tc.len);
        next_cycle();
        drive_core_beat(0, tc.len, tc.bar);
        next_cycle();
        rx_valid        = 1'b0;
        host_rst_subsys = 1'b1;
        next_cycle();
        host_rst_subsys = 1'b0;
    endtask

    // ----------------------------------------
    // Transmit driver
    // ----------------------------------------
    task automatic run_tx_case(input tlp_case_t tc);
        tlp_stream_pkg::user_data_t data [3];
        tlp_stream_pkg::keepdw_t    keepdw [3];
        logic                       last [3];
        tx_beat_t                   q;
        int                         nbeats;
        int                         cnt;
        int                         idx;
        int                         halves;
        fill_payload(tc.seed, tc.len);
        nbeats = (int'(tc.len) + 3) / 4;
        for (int g = 0; g < nbeats; g++) begin
            cnt = tc.len - 4 * g;
            if (cnt > 4) begin
                cnt = 4;
            end
            keepdw[g] = '0;
            for (int k = 0; k < 4; k++) begin
                if (k < cnt) begin
                    data[g][32*k +: 32] = payload[4*g+k];
                    keepdw[g][k] = 1'b1;
                end else begin
                    data[g][32*k +: 32] = rand_bits(32);
                end
            end
            last[g] = (g == nbeats - 1);
            q.data  = data[g][63:0];
            q.keep  = keepdw[g][1] ? 8'hff : 8'h0f;
            q.last  = last[g] && !keepdw[g][2];
            tx_exp.push_back(q);
            if (keepdw[g][2]) begin
                q.data = data[g][127:64];
                q.keep = keepdw[g][3] ? 8'hff : 8'h0f;
                q.last = last[g];
                tx_exp.push_back(q);
            end
        end
        idx    = 0;
        halves = 0;
        while (idx < nbeats) begin
            next_cycle();
            tx_ready     = tc.rand_mode ? next_rand_bit() : 1'b1;
            tx128_valid  = 1'b1;
            tx128_data   = data[idx];
            tx128_keepdw = keepdw[idx];
            tx128_last   = last[idx];
            @(negedge clk_pcie);
            if (tx_valid && tx_ready) begin
                halves++;
            end
            // A two-half beat may only retire together with its high half
            if (tx128_ready) begin
                assert (halves == (keepdw[idx][2] ? 2 : 1))
                    else report_fail($sformatf("user beat %0d taken after %0d core beats",
                                               idx, halves));
                halves = 0;
                idx++;
            end
        end
        next_cycle();
        tx128_valid = 1'b0;
        tx_ready    = 1'b1;
    endtask

    // ----------------------------------------
    // Models and monitors
    // ----------------------------------------
    assign model_rst = rst || core_user_rst || host_rst_subsys;

    always @(posedge clk_pcie or posedge model_rst) begin
        if (model_rst) begin
            led_model <= '0;
        end else begin
            led_model <= led_model + 1;
        end
    end

    always @(posedge clk_pcie) begin
        cyc <= cyc + 1;
    end

    always @(negedge clk_pcie) begin
        if (checks_on) begin
            assert (led_state == (link_up || led_model[3]))
                else report_fail($sformatf("led_state %b, link_up %b, model count %0d",
                                           led_state, link_up, led_model));
            assert (rx_ready == 1'b1) else report_fail("rx_ready low");
            if (rx128_valid) begin
                assert (rx_exp.size() > 0) else report_fail("unexpected receive beat");
                assert (rx_exp[0].cyc == cyc && rx128_keepdw == rx_exp[0].keepdw &&
                        rx128_first == rx_exp[0].first && rx128_last == rx_exp[0].last &&
                        rx128_bar_hit == rx_exp[0].bar)
                    else report_fail($sformatf("rx beat cyc %0d/%0d keep %h/%h f %b l %b bar %h",
                                               cyc, rx_exp[0].cyc, rx128_keepdw,
                                               rx_exp[0].keepdw, rx128_first, rx128_last,
                                               rx128_bar_hit));
                for (int k = 0; k < 4; k++) begin
                    assert (!rx_exp[0].keepdw[k] ||
                            rx128_data[32*k +: 32] == rx_exp[0].data[32*k +: 32])
                        else report_fail($sformatf("rx dword %0d got %h expected %h", k,
                                                   rx128_data[32*k +: 32],
                                                   rx_exp[0].data[32*k +: 32]));
                end
                void'(rx_exp.pop_front());
            end else begin
                assert (rx_exp.size() == 0 || rx_exp[0].cyc > cyc)
                    else report_fail("receive beat missing in its cycle");
            end
            if (tx_valid && tx_ready) begin
                assert (tx_exp.size() > 0) else report_fail("unexpected core transmit beat");
                assert (tx_keep == tx_exp[0].keep && tx_last == tx_exp[0].last &&
                        tx_data[31:0] == tx_exp[0].data[31:0] &&
                        (tx_keep != 8'hff || tx_data[63:32] == tx_exp[0].data[63:32]))
                    else report_fail($sformatf("tx beat %h keep %h last %b expected %h %h %b",
                                               tx_data, tx_keep, tx_last, tx_exp[0].data,
                                               tx_exp[0].keep, tx_exp[0].last));
                void'(tx_exp.pop_front());
            end
        end
    end

    // Watchdog sized from the case table
    initial begin
        int limit;
        limit = total_dwords() * 8 + 200;
        repeat (limit) @(posedge clk_pcie);
        $display("Timeout: the cases did not complete within %0d clock cycles", limit);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst             = 1'b1;
        core_user_rst   = 1'b0;
        host_rst_subsys = 1'b0;
        link_up         = 1'b0;
        rx_data         = '0;
        rx_keep         = '0;
        rx_last         = 1'b0;
        rx_user         = '0;
        rx_valid        = 1'b0;
        tx128_data      = '0;
        tx128_keepdw    = '0;
        tx128_last      = 1'b0;
        tx128_valid     = 1'b0;
        tx_ready        = 1'b1;
        checks_on       = 1'b0;
        cyc             = 0;
        repeat (10) @(posedge clk_pcie);
        #2;
        rst       = 1'b0;
        checks_on = 1'b1;
        for (int i = 0; i < NUM_CASES; i++) begin
            link_up = i[1];
            if (!CASES[i].is_rx) begin
                run_tx_case(CASES[i]);
            end else if (CASES[i].host_rst) begin
                run_rx_reset_case(CASES[i]);
            end else begin
                run_rx_case(CASES[i], (i + 1 < NUM_CASES) && CASES[i+1].is_rx);
            end
        end
        repeat (4) next_cycle();
        assert (rx_exp.size() == 0 && tx_exp.size() == 0)
            else report_fail("expected beats still outstanding at end of run");
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
+incdir+test
src/tlp_stream_pkg.sv
src/link_status_pkg.sv
src/tlp_rx_packer.sv
src/tlp_tx_splitter.sv
src/link_led.sv
src/tlp_width_bridge.sv
test/tlp_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the TLP width bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tlp_bridge_tb \
    -f sim.f \
    -o tlp_bridge_sim

# A failing run exits non-zero, so keep going and decide by the output
out=$(./obj_dir/tlp_bridge_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    echo "Simulation result: pass"
    exit 0
fi

echo "Simulation result: fail"
exit 1
